//--- files.f
src/decode_pkg.sv
src/inst_decoder.sv
src/reg_file.sv
src/operand_forward.sv
src/branch_unit.sv
src/id_stage.sv
test/id_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run the testbench, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module id_stage_tb -f files.f -o id_stage_sim \
    && ./obj_dir/id_stage_sim > sim.log 2>&1
grep -q "^ALL TESTS PASSED$" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { cat sim.log 2>/dev/null; echo "simulation failed"; exit 1; }

//--- src/branch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module branch_unit import decode_pkg::*; (
    input  br_kind_t    br_kind,
    input  word_t       pc,
    input  wire  [25:0] imm26,
    input  word_t       rs_value,
    input  word_t       rt_value,
    output logic        taken,
    output word_t       target
);

    word_t pc_plus4;
    word_t br_offset;
    logic  rs_eq_rt;
    logic  rs_neg;
    logic  rs_zero;

    assign pc_plus4  = pc + word_t'(4);
    assign br_offset = {{14{imm26[15]}}, imm26[15:0], 2'b00};

    assign rs_eq_rt = (rs_value == rt_value);
    assign rs_neg   = rs_value[WORD_W-1];
    assign rs_zero  = (rs_value == '0);

    always_comb begin
        unique case (br_kind)
            BR_BEQ:  taken = rs_eq_rt;
            BR_BNE:  taken = !rs_eq_rt;
            BR_BGEZ: taken = !rs_neg;
            BR_BGTZ: taken = !rs_neg && !rs_zero;
            BR_BLEZ: taken = rs_neg || rs_zero;
            BR_BLTZ: taken = rs_neg;
            BR_J,
            BR_JAL,
            BR_JR:   taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (br_kind)
            BR_J,
            BR_JAL:  target = {pc_plus4[31:28], imm26, 2'b00};
            BR_JR:   target = rs_value;
            // conditional branches, relative to the delay slot
            default: target = pc_plus4 + br_offset;
        endcase
    end

endmodule

`default_nettype wire

//--- src/decode_pkg.sv
`default_nettype none

package decode_pkg;

    localparam int WORD_W    = 32;
    localparam int REG_COUNT = 32;
    localparam int REG_AW    = $clog2(REG_COUNT);

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [11:0]       alu_op_t;
    typedef logic [5:0]        opcode_t;

    // one-hot alu_op bit positions
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_REGIMM  = 6'h01;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_JAL     = 6'h03;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_BLEZ    = 6'h06;
    localparam opcode_t OP_BGTZ    = 6'h07;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_SLTI    = 6'h0a;
    localparam opcode_t OP_SLTIU   = 6'h0b;
    localparam opcode_t OP_ANDI    = 6'h0c;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_XORI    = 6'h0e;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SW      = 6'h2b;

    localparam opcode_t FN_SLL  = 6'h00;
    localparam opcode_t FN_SRL  = 6'h02;
    localparam opcode_t FN_SRA  = 6'h03;
    localparam opcode_t FN_JR   = 6'h08;
    localparam opcode_t FN_ADDU = 6'h21;
    localparam opcode_t FN_SUBU = 6'h23;
    localparam opcode_t FN_AND  = 6'h24;
    localparam opcode_t FN_OR   = 6'h25;
    localparam opcode_t FN_XOR  = 6'h26;
    localparam opcode_t FN_NOR  = 6'h27;
    localparam opcode_t FN_SLT  = 6'h2a;
    localparam opcode_t FN_SLTU = 6'h2b;

    // rt field selects the regimm branch
    localparam reg_addr_t RT_BLTZ = 5'h00;
    localparam reg_addr_t RT_BGEZ = 5'h01;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BGEZ,
        BR_BGTZ,
        BR_BLEZ,
        BR_BLTZ,
        BR_J,
        BR_JAL,
        BR_JR
    } br_kind_t;

    typedef struct packed {
        word_t inst;
        word_t pc;
    } fs_to_ds_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } ws_to_rf_t;

    typedef struct packed {
        reg_addr_t dest;
        word_t     data;
    } bypass_t;

    typedef struct packed {
        alu_op_t   alu_op;
        br_kind_t  br_kind;
        logic      load_op;
        logic      mem_we;
        logic      src1_is_sa;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      src2_is_imm_zero;
        logic      src2_is_8;
        reg_addr_t dest;
        logic      uses_rs;
        logic      uses_rt;
    } dec_ctrl_t;

    typedef struct packed {
        logic        ex_ri;
        alu_op_t     alu_op;
        logic        load_op;
        logic        mem_we;
        logic        src1_is_sa;
        logic        src1_is_pc;
        logic        src2_is_imm;
        logic        src2_is_imm_zero;
        logic        src2_is_8;
        reg_addr_t   dest;
        logic [15:0] imm;
        word_t       rs_value;
        word_t       rt_value;
        word_t       pc;
    } ds_to_es_t;

    typedef struct packed {
        logic  br_stall;
        logic  br_taken;
        word_t br_target;
    } br_bus_t;

endpackage

`default_nettype wire

//--- src/id_stage.sv
`timescale 1ns/10ps
`default_nettype none

module id_stage import decode_pkg::*; (
    input  wire       clk,
    input  wire       reset,
    input  wire       fs_to_ds_valid,
    input  fs_to_ds_t fs_to_ds_bus,
    output logic      ds_allowin,
    output logic      ds_to_es_valid,
    output ds_to_es_t ds_to_es_bus,
    input  wire       es_allowin,
    input  ws_to_rf_t ws_to_rf_bus,
    input  bypass_t   exe_bypass,
    input  bypass_t   mem_bypass,
    input  bypass_t   wb_bypass,
    input  wire       es_load_op,
    output br_bus_t   br_bus
);

    logic      ds_valid;
    logic      ds_ready_go;
    fs_to_ds_t fs_r;
    dec_ctrl_t ctrl;
    logic      ex_ri;
    reg_addr_t rs;
    reg_addr_t rt;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    word_t     rs_value;
    word_t     rt_value;
    logic      load_stall;
    logic      taken;
    word_t     target;
    logic      is_branch;

    assign ds_ready_go    = !load_stall;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            fs_r <= fs_to_ds_bus;
        end
    end

    assign rs = fs_r.inst[25:21];
    assign rt = fs_r.inst[20:16];

    inst_decoder u_dec (
        .inst  (fs_r.inst),
        .ctrl  (ctrl),
        .ex_ri (ex_ri)
    );

    reg_file u_rf (
        .clk    (clk),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (ws_to_rf_bus)
    );

    operand_forward u_fwd (
        .rs         (rs),
        .rt         (rt),
        .uses_rs    (ctrl.uses_rs),
        .uses_rt    (ctrl.uses_rt),
        .rf_rdata1  (rf_rdata1),
        .rf_rdata2  (rf_rdata2),
        .exe_bypass (exe_bypass),
        .mem_bypass (mem_bypass),
        .wb_bypass  (wb_bypass),
        .es_load_op (es_load_op),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .load_stall (load_stall)
    );

    branch_unit u_br (
        .br_kind  (ctrl.br_kind),
        .pc       (fs_r.pc),
        .imm26    (fs_r.inst[25:0]),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .taken    (taken),
        .target   (target)
    );

    assign is_branch = (ctrl.br_kind != BR_NONE);

    // fetch holds off while the branch operands are not ready
    assign br_bus.br_stall  = ds_valid && is_branch && load_stall;
    assign br_bus.br_taken  = ds_valid && taken;
    assign br_bus.br_target = target;

    always_comb begin
        ds_to_es_bus.ex_ri            = ex_ri;
        ds_to_es_bus.alu_op           = ctrl.alu_op;
        ds_to_es_bus.load_op          = ctrl.load_op;
        ds_to_es_bus.mem_we           = ctrl.mem_we;
        ds_to_es_bus.src1_is_sa       = ctrl.src1_is_sa;
        ds_to_es_bus.src1_is_pc       = ctrl.src1_is_pc;
        ds_to_es_bus.src2_is_imm      = ctrl.src2_is_imm;
        ds_to_es_bus.src2_is_imm_zero = ctrl.src2_is_imm_zero;
        ds_to_es_bus.src2_is_8        = ctrl.src2_is_8;
        ds_to_es_bus.dest             = ctrl.dest;
        ds_to_es_bus.imm              = fs_r.inst[15:0];
        ds_to_es_bus.rs_value         = rs_value;
        ds_to_es_bus.rt_value         = rt_value;
        ds_to_es_bus.pc               = fs_r.pc;
    end

    // an offered instruction stays valid until execute takes it
    a_valid_held: assert property (
        @(posedge clk) disable iff (reset)
        (ds_to_es_valid && !es_allowin) |=> ds_to_es_valid
    );

endmodule

`default_nettype wire

//--- src/inst_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module inst_decoder import decode_pkg::*; (
    input  word_t     inst,
    output dec_ctrl_t ctrl,
    output logic      ex_ri
);

    opcode_t   op;
    opcode_t   fn;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    reg_addr_t sa;

    logic special;
    logic inst_addu, inst_subu, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_xor, inst_nor;
    logic inst_sll, inst_srl, inst_sra;
    logic inst_addiu, inst_slti, inst_sltiu, inst_andi, inst_ori, inst_xori, inst_lui;
    logic inst_lw, inst_sw;
    logic inst_beq, inst_bne, inst_bgez, inst_bgtz, inst_blez, inst_bltz;
    logic inst_j, inst_jal, inst_jr;
    logic r_alu;
    logic shift;
    logic imm_alu;
    logic cond_br;
    logic dst_is_rt;
    logic no_dest;

    assign op = inst[31:26];
    assign rs = inst[25:21];
    assign rt = inst[20:16];
    assign rd = inst[15:11];
    assign sa = inst[10:6];
    assign fn = inst[5:0];

    assign special = (op == OP_SPECIAL);

    // three-register forms need sa == 0
    assign inst_addu = special && fn == FN_ADDU && sa == '0;
    assign inst_subu = special && fn == FN_SUBU && sa == '0;
    assign inst_slt  = special && fn == FN_SLT  && sa == '0;
    assign inst_sltu = special && fn == FN_SLTU && sa == '0;
    assign inst_and  = special && fn == FN_AND  && sa == '0;
    assign inst_or   = special && fn == FN_OR   && sa == '0;
    assign inst_xor  = special && fn == FN_XOR  && sa == '0;
    assign inst_nor  = special && fn == FN_NOR  && sa == '0;

    // shifts by sa need rs == 0
    assign inst_sll = special && fn == FN_SLL && rs == '0;
    assign inst_srl = special && fn == FN_SRL && rs == '0;
    assign inst_sra = special && fn == FN_SRA && rs == '0;
    assign inst_jr  = special && fn == FN_JR && rt == '0 && rd == '0 && sa == '0;

    assign inst_addiu = (op == OP_ADDIU);
    assign inst_slti  = (op == OP_SLTI);
    assign inst_sltiu = (op == OP_SLTIU);
    assign inst_andi  = (op == OP_ANDI);
    assign inst_ori   = (op == OP_ORI);
    assign inst_xori  = (op == OP_XORI);
    assign inst_lui   = (op == OP_LUI) && rs == '0;
    assign inst_lw    = (op == OP_LW);
    assign inst_sw    = (op == OP_SW);

    assign inst_beq  = (op == OP_BEQ);
    assign inst_bne  = (op == OP_BNE);
    assign inst_blez = (op == OP_BLEZ) && rt == '0;
    assign inst_bgtz = (op == OP_BGTZ) && rt == '0;
    assign inst_bltz = (op == OP_REGIMM) && rt == RT_BLTZ;
    assign inst_bgez = (op == OP_REGIMM) && rt == RT_BGEZ;
    assign inst_j    = (op == OP_J);
    assign inst_jal  = (op == OP_JAL);

    assign r_alu   = inst_addu | inst_subu | inst_slt | inst_sltu |
                     inst_and | inst_or | inst_xor | inst_nor;
    assign shift   = inst_sll | inst_srl | inst_sra;
    assign imm_alu = inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori | inst_xori;
    assign cond_br = inst_beq | inst_bne | inst_bgez | inst_bgtz | inst_blez | inst_bltz;

    assign dst_is_rt = imm_alu | inst_lui | inst_lw;
    assign no_dest   = inst_sw | cond_br | inst_j | inst_jr;

    assign ex_ri = ~(r_alu | shift | imm_alu | inst_lui | inst_lw | inst_sw |
                     cond_br | inst_j | inst_jal | inst_jr);

    always_comb begin
        ctrl = '0;

        ctrl.alu_op[ALU_ADD]  = inst_addu | inst_addiu | inst_lw | inst_sw | inst_jal;
        ctrl.alu_op[ALU_SUB]  = inst_subu;
        ctrl.alu_op[ALU_SLT]  = inst_slt | inst_slti;
        ctrl.alu_op[ALU_SLTU] = inst_sltu | inst_sltiu;
        ctrl.alu_op[ALU_AND]  = inst_and | inst_andi;
        ctrl.alu_op[ALU_NOR]  = inst_nor;
        ctrl.alu_op[ALU_OR]   = inst_or | inst_ori;
        ctrl.alu_op[ALU_XOR]  = inst_xor | inst_xori;
        ctrl.alu_op[ALU_SLL]  = inst_sll;
        ctrl.alu_op[ALU_SRL]  = inst_srl;
        ctrl.alu_op[ALU_SRA]  = inst_sra;
        ctrl.alu_op[ALU_LUI]  = inst_lui;

        if (inst_beq)       ctrl.br_kind = BR_BEQ;
        else if (inst_bne)  ctrl.br_kind = BR_BNE;
        else if (inst_bgez) ctrl.br_kind = BR_BGEZ;
        else if (inst_bgtz) ctrl.br_kind = BR_BGTZ;
        else if (inst_blez) ctrl.br_kind = BR_BLEZ;
        else if (inst_bltz) ctrl.br_kind = BR_BLTZ;
        else if (inst_j)    ctrl.br_kind = BR_J;
        else if (inst_jal)  ctrl.br_kind = BR_JAL;
        else if (inst_jr)   ctrl.br_kind = BR_JR;
        else                ctrl.br_kind = BR_NONE;

        ctrl.load_op          = inst_lw;
        ctrl.mem_we           = inst_sw;
        ctrl.src1_is_sa       = shift;
        // jal computes pc + 8 for the link
        ctrl.src1_is_pc       = inst_jal;
        ctrl.src2_is_8        = inst_jal;
        ctrl.src2_is_imm      = inst_addiu | inst_slti | inst_sltiu | inst_lui |
                                inst_lw | inst_sw;
        ctrl.src2_is_imm_zero = inst_andi | inst_ori | inst_xori;

        if (inst_jal)       ctrl.dest = reg_addr_t'(31);
        else if (dst_is_rt) ctrl.dest = rt;
        else if (no_dest)   ctrl.dest = '0;
        else                ctrl.dest = rd;

        ctrl.uses_rs = r_alu | imm_alu | inst_lw | inst_sw | cond_br | inst_jr;
        ctrl.uses_rt = r_alu | shift | inst_sw | inst_beq | inst_bne;
    end

endmodule

`default_nettype wire

//--- src/operand_forward.sv
`timescale 1ns/10ps
`default_nettype none

module operand_forward import decode_pkg::*; (
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    input  wire       uses_rs,
    input  wire       uses_rt,
    input  word_t     rf_rdata1,
    input  word_t     rf_rdata2,
    input  bypass_t   exe_bypass,
    input  bypass_t   mem_bypass,
    input  bypass_t   wb_bypass,
    input  wire       es_load_op,
    output word_t     rs_value,
    output word_t     rt_value,
    output logic      load_stall
);

    logic rs_exe, rs_mem, rs_wb;
    logic rt_exe, rt_mem, rt_wb;

    // r0 and unread sources never take a bypass
    function automatic logic hits(input reg_addr_t src, input logic used, input bypass_t byp);
        return used && src != '0 && byp.dest == src;
    endfunction

    assign rs_exe = hits(rs, uses_rs, exe_bypass);
    assign rs_mem = hits(rs, uses_rs, mem_bypass);
    assign rs_wb  = hits(rs, uses_rs, wb_bypass);
    assign rt_exe = hits(rt, uses_rt, exe_bypass);
    assign rt_mem = hits(rt, uses_rt, mem_bypass);
    assign rt_wb  = hits(rt, uses_rt, wb_bypass);

    // youngest producer wins
    assign rs_value = rs_exe ? exe_bypass.data :
                      rs_mem ? mem_bypass.data :
                      rs_wb  ? wb_bypass.data  : rf_rdata1;
    assign rt_value = rt_exe ? exe_bypass.data :
                      rt_mem ? mem_bypass.data :
                      rt_wb  ? wb_bypass.data  : rf_rdata2;

    // load data is not ready until mem
    assign load_stall = es_load_op && (rs_exe || rt_exe);

endmodule

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file import decode_pkg::*; (
    input  wire       clk,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2,
    input  ws_to_rf_t wr
);

    // register 0 has no storage
    word_t regs [1:REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (wr.we && wr.waddr != '0) begin
            regs[wr.waddr] <= wr.wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- test/id_stage_tb.sv
`timescale 1ns/10ps
`default_nettype none

module id_stage_tb import decode_pkg::*; ();

    localparam int    TIMEOUT = 50;
    localparam word_t PC_BASE = 32'hbfc0_0100;

    // bit order {src1_is_sa, src1_is_pc, src2_is_imm, src2_is_imm_zero, src2_is_8}
    localparam logic [4:0] SEL_SA   = 5'b10000;
    localparam logic [4:0] SEL_PC   = 5'b01000;
    localparam logic [4:0] SEL_IMM  = 5'b00100;
    localparam logic [4:0] SEL_IMMZ = 5'b00010;
    localparam logic [4:0] SEL_8    = 5'b00001;

    // forwarded data, one value per stage
    localparam word_t FA = 32'h0a0a_0001;
    localparam word_t FB = 32'h0b0b_0002;
    localparam word_t FC = 32'h0c0c_0003;

    typedef struct {
        string       name;
        word_t       inst;
        word_t       pc;
        bypass_t     exe;
        bypass_t     mem;
        bypass_t     wb;
        logic        load;
        logic        hold;
        logic        ex_ri;
        alu_op_t     alu_op;
        logic        load_op;
        logic        mem_we;
        logic [4:0]  sel;
        reg_addr_t   dest;
        logic [15:0] imm;
        word_t       rs_value;
        word_t       rt_value;
        logic        is_branch;
        logic        br_taken;
        word_t       br_target;
    } vec_t;

    logic      clk;
    logic      reset;
    logic      fs_to_ds_valid;
    fs_to_ds_t fs_to_ds_bus;
    logic      ds_allowin;
    logic      ds_to_es_valid;
    ds_to_es_t ds_to_es_bus;
    logic      es_allowin;
    ws_to_rf_t ws_to_rf_bus;
    bypass_t   exe_bypass;
    bypass_t   mem_bypass;
    bypass_t   wb_bypass;
    logic      es_load_op;
    br_bus_t   br_bus;

    word_t rf_exp [0:31];
    vec_t  vecs [$];
    string cur_name;

    id_stage UUT (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .ds_allowin     (ds_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .es_allowin     (es_allowin),
        .ws_to_rf_bus   (ws_to_rf_bus),
        .exe_bypass     (exe_bypass),
        .mem_bypass     (mem_bypass),
        .wb_bypass      (wb_bypass),
        .es_load_op     (es_load_op),
        .br_bus         (br_bus)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_now();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("Error: %s %s expected %h actual %h", cur_name, what, exp, act);
            fail_now();
        end
    endtask

    task automatic check_addr(input string what, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            $display("Error: %s %s expected %0d actual %0d", cur_name, what, exp, act);
            fail_now();
        end
    endtask

    task automatic check_alu(input string what, input alu_op_t exp, input alu_op_t act);
        if (act !== exp) begin
            $display("Error: %s %s expected %b actual %b", cur_name, what, exp, act);
            fail_now();
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error: %s %s expected %b actual %b", cur_name, what, exp, act);
            fail_now();
        end
    endtask

    task automatic check_bus(input string what, input ds_to_es_t exp, input ds_to_es_t act);
        if (act !== exp) begin
            $display("Error: %s %s expected %h actual %h", cur_name, what, exp, act);
            fail_now();
        end
    endtask

    function automatic word_t r_type(input reg_addr_t rs, input reg_addr_t rt,
                                     input reg_addr_t rd, input logic [4:0] sa,
                                     input opcode_t fn);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t i_type(input opcode_t op, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t j_type(input opcode_t op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    function automatic alu_op_t one_hot(input int pos);
        return alu_op_t'(1) << pos;
    endfunction

    function automatic bypass_t byp(input reg_addr_t d, input word_t v);
        return '{dest: d, data: v};
    endfunction

    // pc + 4 plus the sign-extended word offset
    function automatic word_t br_dest(input word_t pc, input logic [15:0] off);
        return pc + 32'd4 + {{14{off[15]}}, off, 2'b00};
    endfunction

    function automatic word_t jmp_dest(input word_t pc, input logic [25:0] idx);
        word_t pc4;
        pc4 = pc + 32'd4;
        return {pc4[31:28], idx, 2'b00};
    endfunction

    // no bypass match and register file operands unless an entry says otherwise
    function automatic vec_t blank(input string name, input word_t inst);
        vec_t t;
        t.name      = name;
        t.inst      = inst;
        t.pc        = PC_BASE + word_t'(vecs.size() * 4);
        t.exe       = byp(5'd0, 32'hee00_0001);
        t.mem       = byp(5'd0, 32'hdd00_0002);
        t.wb        = byp(5'd0, 32'hcc00_0003);
        t.load      = 1'b0;
        t.hold      = 1'b0;
        t.ex_ri     = 1'b0;
        t.alu_op    = '0;
        t.load_op   = 1'b0;
        t.mem_we    = 1'b0;
        t.sel       = '0;
        t.dest      = '0;
        t.imm       = inst[15:0];
        t.rs_value  = rf_exp[inst[25:21]];
        t.rt_value  = rf_exp[inst[20:16]];
        t.is_branch = 1'b0;
        t.br_taken  = 1'b0;
        t.br_target = '0;
        return t;
    endfunction

    task automatic write_reg(input reg_addr_t a, input word_t d);
        @(posedge clk);
        ws_to_rf_bus <= '{we: 1'b1, waddr: a, wdata: d};
        if (a != '0) begin
            rf_exp[a] = d;
        end
    endtask

    task automatic preload();
        int k;
        for (k = 0; k < 32; k++) begin
            write_reg(reg_addr_t'(k), 32'hc000_0000 | (word_t'(k) << 16) | word_t'(k));
        end
        // operands for the branch compares
        write_reg(5'd3, 32'hffff_fff0);
        write_reg(5'd4, 32'h0000_0000);
        write_reg(5'd5, 32'h0000_0007);
        write_reg(5'd6, 32'h0000_0007);
        write_reg(5'd31, 32'h0040_1000);
        @(posedge clk);
        ws_to_rf_bus.we <= 1'b0;
    endtask

    task automatic add_branch(input string name, input word_t inst, input logic taken);
        vec_t t;
        t = blank(name, inst);
        t.is_branch = 1'b1;
        t.br_taken  = taken;
        t.br_target = br_dest(t.pc, inst[15:0]);
        vecs.push_back(t);
    endtask

    task automatic build_vectors();
        vec_t      t;
        int        s;
        int        lv;
        reg_addr_t src;
        word_t     fwd;

        t = blank("addu", r_type(5'd1, 5'd2, 5'd7, 5'd0, FN_ADDU));
        t.alu_op = one_hot(ALU_ADD);
        t.dest   = 5'd7;
        vecs.push_back(t);

        t = blank("sll", r_type(5'd0, 5'd2, 5'd14, 5'd3, FN_SLL));
        t.alu_op = one_hot(ALU_SLL);
        t.sel    = SEL_SA;
        t.dest   = 5'd14;
        vecs.push_back(t);

        // rt is not read by ori so the exe match is ignored
        t = blank("ori_rt_unused", i_type(OP_ORI, 5'd2, 5'd9, 16'h8001));
        t.exe    = byp(5'd9, FA);
        t.alu_op = one_hot(ALU_OR);
        t.sel    = SEL_IMMZ;
        t.dest   = 5'd9;
        vecs.push_back(t);

        t = blank("lui", i_type(OP_LUI, 5'd0, 5'd10, 16'h1234));
        t.alu_op = one_hot(ALU_LUI);
        t.sel    = SEL_IMM;
        t.dest   = 5'd10;
        vecs.push_back(t);

        t = blank("lw", i_type(OP_LW, 5'd1, 5'd11, 16'hfffc));
        t.alu_op  = one_hot(ALU_ADD);
        t.load_op = 1'b1;
        t.sel     = SEL_IMM;
        t.dest    = 5'd11;
        vecs.push_back(t);

        t = blank("sw", i_type(OP_SW, 5'd1, 5'd12, 16'h0008));
        t.alu_op = one_hot(ALU_ADD);
        t.mem_we = 1'b1;
        t.sel    = SEL_IMM;
        vecs.push_back(t);

        // r0 was written during preload and must still read zero
        t = blank("addu_r0", r_type(5'd0, 5'd0, 5'd13, 5'd0, FN_ADDU));
        t.alu_op = one_hot(ALU_ADD);
        t.dest   = 5'd13;
        vecs.push_back(t);

        // lv 0 puts the source in exe, mem and wb, lv 2 only in wb
        for (s = 0; s < 2; s++) begin
            for (lv = 0; lv < 3; lv++) begin
                t = blank($sformatf("fwd_%s_%s", (s == 1) ? "rt" : "rs",
                                    (lv == 0) ? "exe" : (lv == 1) ? "mem" : "wb"),
                          r_type(5'd1, 5'd2, 5'd7, 5'd0, FN_ADDU));
                src = (s == 1) ? 5'd2 : 5'd1;
                fwd = (lv == 0) ? FA : (lv == 1) ? FB : FC;
                if (lv == 0) t.exe = byp(src, FA);
                if (lv <= 1) t.mem = byp(src, FB);
                t.wb     = byp(src, FC);
                t.alu_op = one_hot(ALU_ADD);
                t.dest   = 5'd7;
                if (s == 1) t.rt_value = fwd;
                else        t.rs_value = fwd;
                vecs.push_back(t);
            end
        end

        t = blank("load_use_alu", r_type(5'd1, 5'd2, 5'd7, 5'd0, FN_ADDU));
        t.exe      = byp(5'd2, FA);
        t.load     = 1'b1;
        t.alu_op   = one_hot(ALU_ADD);
        t.dest     = 5'd7;
        t.rt_value = FA;
        vecs.push_back(t);

        // rs equals rt only through the exe value
        t = blank("load_use_beq", i_type(OP_BEQ, 5'd1, 5'd6, 16'h0010));
        t.exe       = byp(5'd1, 32'd7);
        t.load      = 1'b1;
        t.rs_value  = 32'd7;
        t.is_branch = 1'b1;
        t.br_taken  = 1'b1;
        t.br_target = br_dest(t.pc, 16'h0010);
        vecs.push_back(t);

        add_branch("beq_taken", i_type(OP_BEQ, 5'd5, 5'd6, 16'h0010), 1'b1);
        add_branch("beq_not", i_type(OP_BEQ, 5'd5, 5'd1, 16'h0010), 1'b0);
        add_branch("bne_back", i_type(OP_BNE, 5'd5, 5'd1, 16'hfff0), 1'b1);
        add_branch("bgez_zero", i_type(OP_REGIMM, 5'd4, RT_BGEZ, 16'h0020), 1'b1);
        add_branch("bltz_neg", i_type(OP_REGIMM, 5'd3, RT_BLTZ, 16'h0004), 1'b1);
        add_branch("bgtz_zero", i_type(OP_BGTZ, 5'd4, 5'd0, 16'h0008), 1'b0);
        add_branch("blez_neg", i_type(OP_BLEZ, 5'd3, 5'd0, 16'hff00), 1'b1);

        t = blank("j", j_type(OP_J, 26'h012_3456));
        t.is_branch = 1'b1;
        t.br_taken  = 1'b1;
        t.br_target = jmp_dest(t.pc, 26'h012_3456);
        vecs.push_back(t);

        // link value is pc + 8
        t = blank("jal", j_type(OP_JAL, 26'h000_0400));
        t.alu_op    = one_hot(ALU_ADD);
        t.sel       = SEL_PC | SEL_8;
        t.dest      = 5'd31;
        t.is_branch = 1'b1;
        t.br_taken  = 1'b1;
        t.br_target = jmp_dest(t.pc, 26'h000_0400);
        vecs.push_back(t);

        t = blank("jr", r_type(5'd31, 5'd0, 5'd0, 5'd0, FN_JR));
        t.is_branch = 1'b1;
        t.br_taken  = 1'b1;
        t.br_target = rf_exp[31];
        vecs.push_back(t);

        t = blank("reserved_op", 32'hfc00_0000);
        t.ex_ri = 1'b1;
        vecs.push_back(t);

        // addu with a nonzero sa field is outside the set
        t = blank("reserved_sa", r_type(5'd1, 5'd2, 5'd3, 5'd4, FN_ADDU));
        t.ex_ri = 1'b1;
        t.dest  = 5'd3;
        vecs.push_back(t);

        t = blank("backpressure", r_type(5'd1, 5'd2, 5'd8, 5'd0, FN_ADDU));
        t.hold     = 1'b1;
        t.wb       = byp(5'd1, FC);
        t.alu_op   = one_hot(ALU_ADD);
        t.dest     = 5'd8;
        t.rs_value = FC;
        vecs.push_back(t);
    endtask

    task automatic wait_allowin();
        int n;
        n = 0;
        @(negedge clk);
        while (!ds_allowin) begin
            if (n == TIMEOUT) begin
                $display("timeout: %s found the stage never ready to accept", cur_name);
                fail_now();
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic wait_out_valid();
        int n;
        n = 0;
        while (!ds_to_es_valid) begin
            if (n == TIMEOUT) begin
                $display("timeout: %s never presented a valid output", cur_name);
                fail_now();
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic check_outputs(input vec_t t);
        check_bit("ex_ri", t.ex_ri, ds_to_es_bus.ex_ri);
        check_alu("alu_op", t.alu_op, ds_to_es_bus.alu_op);
        check_bit("load_op", t.load_op, ds_to_es_bus.load_op);
        check_bit("mem_we", t.mem_we, ds_to_es_bus.mem_we);
        check_bit("src1_is_sa", t.sel[4], ds_to_es_bus.src1_is_sa);
        check_bit("src1_is_pc", t.sel[3], ds_to_es_bus.src1_is_pc);
        check_bit("src2_is_imm", t.sel[2], ds_to_es_bus.src2_is_imm);
        check_bit("src2_is_imm_zero", t.sel[1], ds_to_es_bus.src2_is_imm_zero);
        check_bit("src2_is_8", t.sel[0], ds_to_es_bus.src2_is_8);
        check_addr("dest", t.dest, ds_to_es_bus.dest);
        check_word("imm", word_t'(t.imm), word_t'(ds_to_es_bus.imm));
        check_word("rs_value", t.rs_value, ds_to_es_bus.rs_value);
        check_word("rt_value", t.rt_value, ds_to_es_bus.rt_value);
        check_word("pc", t.pc, ds_to_es_bus.pc);
        check_bit("ds_allowin", 1'b1, ds_allowin);
        check_bit("br_stall", 1'b0, br_bus.br_stall);
        check_bit("br_taken", t.br_taken, br_bus.br_taken);
        if (t.br_taken) begin
            check_word("br_target", t.br_target, br_bus.br_target);
        end
    endtask

    task automatic run_entry(input vec_t t);
        ds_to_es_t held;
        cur_name = t.name;
        wait_allowin();
        @(posedge clk);
        fs_to_ds_valid <= 1'b1;
        fs_to_ds_bus   <= '{inst: t.inst, pc: t.pc};
        exe_bypass     <= t.exe;
        mem_bypass     <= t.mem;
        wb_bypass      <= t.wb;
        es_load_op     <= t.load;
        es_allowin     <= !t.hold;
        @(posedge clk);
        if (t.hold) begin
            // the next fetch word waits while the stage is blocked
            fs_to_ds_bus <= '{inst: ~t.inst, pc: t.pc + 32'd4};
        end else begin
            fs_to_ds_valid <= 1'b0;
        end
        @(negedge clk);
        if (t.load) begin
            repeat (2) begin
                check_bit("ds_to_es_valid in stall", 1'b0, ds_to_es_valid);
                check_bit("ds_allowin in stall", 1'b0, ds_allowin);
                check_bit("br_stall in stall", t.is_branch, br_bus.br_stall);
                @(negedge clk);
            end
            @(posedge clk);
            es_load_op <= 1'b0;
            @(negedge clk);
        end
        if (t.hold) begin
            held = ds_to_es_bus;
            repeat (3) begin
                check_bit("ds_to_es_valid while blocked", 1'b1, ds_to_es_valid);
                check_bit("ds_allowin while blocked", 1'b0, ds_allowin);
                check_bus("ds_to_es_bus while blocked", held, ds_to_es_bus);
                @(negedge clk);
            end
            @(posedge clk);
            fs_to_ds_valid <= 1'b0;
            es_allowin     <= 1'b1;
            @(negedge clk);
        end
        wait_out_valid();
        check_outputs(t);
    endtask

    initial begin
        reset          = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_to_ds_bus   = '0;
        es_allowin     = 1'b1;
        ws_to_rf_bus   = '0;
        exe_bypass     = '0;
        mem_bypass     = '0;
        wb_bypass      = '0;
        es_load_op     = 1'b0;
        rf_exp[0]      = '0;

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        cur_name = "after_reset";
        check_bit("ds_to_es_valid", 1'b0, ds_to_es_valid);
        check_bit("ds_allowin", 1'b1, ds_allowin);
        check_bit("br_taken", 1'b0, br_bus.br_taken);
        check_bit("br_stall", 1'b0, br_bus.br_stall);

        preload();
        build_vectors();
        foreach (vecs[i]) begin
            run_entry(vecs[i]);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
